// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module reservationStationTb -o simRs
./obj_dir/simRs | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation finished without failures"

// File: source/entryArray.sv
`timescale 1ns/1ps
`default_nettype none

module entryArray #(
    parameter int NumEntries = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 dispatchValid,
    input  rsPkg::dispatchPacket                 dispatch,
    input  rsPkg::resultBusArray                 results,
    input  logic [NumEntries-1:0]                freeMask,
    output logic [NumEntries-1:0]                readyMask,
    output rsPkg::issuePacket [NumEntries-1:0]   entries
);
    import rsPkg::*;

    logic [NumEntries-1:0]    busy;
    logic [NumEntries-1:0]    present1;
    logic [NumEntries-1:0]    present2;
    logic [NumEntries-1:0]    allocMask;
    logic [NumEntries-1:0]    hit1;
    logic [NumEntries-1:0]    hit2;
    microOp  [NumEntries-1:0] opStore;
    tagType  [NumEntries-1:0] tag1;
    tagType  [NumEntries-1:0] tag2;
    dataType [NumEntries-1:0] value1;
    dataType [NumEntries-1:0] value2;
    dataType [NumEntries-1:0] wake1;
    dataType [NumEntries-1:0] wake2;

    // lowest zero bit of busy, all zero when full
    assign allocMask = ~busy & (busy + 1'b1);

    for (genvar e = 0; e < NumEntries; e++) begin : gSnoop
        operandSnoop snoopSrc1_inst (
            .tag     (tag1[e]),
            .results (results),
            .hit     (hit1[e]),
            .value   (wake1[e])
        );

        operandSnoop snoopSrc2_inst (
            .tag     (tag2[e]),
            .results (results),
            .hit     (hit2[e]),
            .value   (wake2[e])
        );
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= '0;
            present1 <= '0;
            present2 <= '0;
        end else begin
            for (int e = 0; e < NumEntries; e++) begin
                if (freeMask[e]) begin
                    busy[e] <= 1'b0; // issued this edge
                end else if (dispatchValid && allocMask[e]) begin
                    busy[e]     <= 1'b1;
                    present1[e] <= dispatch.src1.present;
                    present2[e] <= dispatch.src2.present;
                end else begin
                    if (hit1[e]) begin
                        present1[e] <= 1'b1;
                    end
                    if (hit2[e]) begin
                        present2[e] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < NumEntries; e++) begin
            if (dispatchValid && allocMask[e]) begin
                opStore[e] <= dispatch.op;
                tag1[e]    <= dispatch.src1.tag;
                tag2[e]    <= dispatch.src2.tag;
                value1[e]  <= dispatch.src1.value;
                value2[e]  <= dispatch.src2.value;
            end else begin
                // a captured value must survive later reuse of the same tag
                if (hit1[e] && !present1[e]) begin
                    value1[e] <= wake1[e];
                end
                if (hit2[e] && !present2[e]) begin
                    value2[e] <= wake2[e];
                end
            end
        end
    end

    assign readyMask = busy & present1 & present2;

    always_comb begin
        for (int e = 0; e < NumEntries; e++) begin
            entries[e].op     = opStore[e];
            entries[e].value1 = value1[e];
            entries[e].value2 = value2[e];
        end
    end

endmodule

`default_nettype wire

// File: source/issueSelect.sv
`timescale 1ns/1ps
`default_nettype none

module issueSelect #(
    parameter int NumEntries = 8
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [NumEntries-1:0]              readyMask,
    input  rsPkg::issuePacket [NumEntries-1:0] entries,
    output logic [NumEntries-1:0]              freeMask,
    output logic                               issueValid,
    output rsPkg::issuePacket                  issue,
    output logic                               creditReturn
);
    import rsPkg::*;

    issuePacket picked;
    logic       anyReady;

    assign anyReady = |readyMask;

    // isolate lowest set bit
    assign freeMask = readyMask & (~readyMask + 1'b1);

    always_comb begin
        picked = '0;
        for (int e = 0; e < NumEntries; e++) begin
            if (freeMask[e]) begin
                picked = entries[e]; // one-hot, at most one match
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= anyReady;
        end
    end

    always_ff @(posedge clk) begin
        if (anyReady) begin
            issue <= picked;
        end
    end

    // one credit per issued op
    assign creditReturn = issueValid;

endmodule

`default_nettype wire

// File: source/operandSnoop.sv
`timescale 1ns/1ps
`default_nettype none

module operandSnoop (
    input  rsPkg::tagType        tag,
    input  rsPkg::resultBusArray results,
    output logic                 hit,
    output rsPkg::dataType       value
);
    import rsPkg::*;

    // walk from the highest bus down so the lowest matching index is written last
    always_comb begin
        hit   = 1'b0;
        value = '0;
        for (int b = NumBuses - 1; b >= 0; b--) begin
            if (results[b].valid && results[b].tag == tag) begin
                hit   = 1'b1;
                value = results[b].value;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/reservationStation.sv
`timescale 1ns/1ps
`default_nettype none

module reservationStation #(
    parameter int NumEntries = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatchValid,
    input  rsPkg::dispatchPacket dispatch,
    input  rsPkg::resultBusArray results,
    output logic                 issueValid,
    output rsPkg::issuePacket    issue,
    output logic                 creditReturn
);
    import rsPkg::*;

    logic                         hit1;
    logic                         hit2;
    dataType                      snoopValue1;
    dataType                      snoopValue2;
    dispatchPacket                resolved;
    logic [NumEntries-1:0]        readyMask;
    logic [NumEntries-1:0]        freeMask;
    issuePacket [NumEntries-1:0]  entries;

    operandSnoop dispatchSnoop1_inst (
        .tag     (dispatch.src1.tag),
        .results (results),
        .hit     (hit1),
        .value   (snoopValue1)
    );

    operandSnoop dispatchSnoop2_inst (
        .tag     (dispatch.src2.tag),
        .results (results),
        .hit     (hit2),
        .value   (snoopValue2)
    );

    // same-cycle broadcast fills a missing operand
    always_comb begin
        resolved = dispatch;
        if (!dispatch.src1.present && hit1) begin
            resolved.src1.present = 1'b1;
            resolved.src1.value   = snoopValue1;
        end
        if (!dispatch.src2.present && hit2) begin
            resolved.src2.present = 1'b1;
            resolved.src2.value   = snoopValue2;
        end
    end

    entryArray #(
        .NumEntries (NumEntries)
    ) entryArray_inst (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatch      (resolved),
        .results       (results),
        .freeMask      (freeMask),
        .readyMask     (readyMask),
        .entries       (entries)
    );

    issueSelect #(
        .NumEntries (NumEntries)
    ) issueSelect_inst (
        .clk          (clk),
        .reset        (reset),
        .readyMask    (readyMask),
        .entries      (entries),
        .freeMask     (freeMask),
        .issueValid   (issueValid),
        .issue        (issue),
        .creditReturn (creditReturn)
    );

endmodule

`default_nettype wire

// File: source/rsPkg.sv
`default_nettype none

package rsPkg;

    localparam int TagWidth  = 8;
    localparam int DataWidth = 32;
    localparam int NumBuses  = 4;

    // result bus slots, lower index wins on a tag tie
    typedef enum logic [1:0] {
        busAlu,
        busMul,
        busDiv,
        busLoad
    } busIndex;

    typedef logic [TagWidth-1:0]  tagType;
    typedef logic [DataWidth-1:0] dataType;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opShiftLeft,
        opShiftRight,
        opMultiply,
        opDivide,
        opLoad,
        opStore,
        opBranch,
        opJump
    } opcodeType;

    typedef struct packed {
        logic [31:0] pc;
        tagType      destTag;
        opcodeType   opcode;
        logic [31:0] immediate; // opaque here
    } microOp;

    typedef struct packed {
        tagType  tag;
        logic    present;
        dataType value; // meaningful only when present
    } srcOperand;

    typedef struct packed {
        microOp    op;
        srcOperand src1;
        srcOperand src2;
    } dispatchPacket;

    typedef struct packed {
        logic    valid;
        tagType  tag;
        dataType value;
    } resultBus;

    typedef struct packed {
        microOp  op;
        dataType value1;
        dataType value2;
    } issuePacket;

    typedef resultBus [NumBuses-1:0] resultBusArray;

endpackage

`default_nettype wire

// File: verification/reservationStationTb.sv
`timescale 1ns/1ps
`default_nettype none

module reservationStationTb;
    import rsPkg::*;

    localparam int NumEntries = 8;

    logic          clk;
    logic          reset;
    logic          dispatchValid;
    dispatchPacket dispatch;
    resultBusArray results;
    logic          issueValid;
    issuePacket    issue;
    logic          creditReturn;

    issuePacket expected[$]; // issues in the order the case file lists them
    issuePacket want;
    microOp     opByPc [logic [31:0]];
    int         sent        = 0;
    int         returned    = 0;
    int         expectCount = 0;
    int         cycles      = 0;
    int         cycleLimit  = 1000;

    reservationStation #(
        .NumEntries (NumEntries)
    ) reservationStation_inst (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .results       (results),
        .issueValid    (issueValid),
        .issue         (issue),
        .creditReturn  (creditReturn)
    );

    task automatic abortRun(input string reason);
        $display("%0t ns: %s", $time, reason);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abortRun("value mismatch");
        end
    endtask

    // one clock per call with inputs back to idle after the edge
    task automatic advance(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            dispatchValid = 1'b0;
            dispatch      = '0;
            results       = '0;
        end
    endtask

    function automatic int busFromName(input logic [8*8-1:0] name);
        if (name == "alu") return int'(busAlu);
        if (name == "mul") return int'(busMul);
        if (name == "div") return int'(busDiv);
        if (name == "load") return int'(busLoad);
        return -1;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            abortRun("timeout, the expected issues did not all arrive");
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (creditReturn) returned++;
            if (issueValid && expected.size() == 0) begin
                abortRun("the station issued an op that no expect line asked for");
            end else if (issueValid) begin
                want = expected.pop_front();
                checkValue("creditReturn with an issue", creditReturn, 1);
                checkValue("pc", issue.op.pc, want.op.pc);
                checkValue("destTag", issue.op.destTag, want.op.destTag);
                checkValue("opcode", issue.op.opcode, want.op.opcode);
                checkValue("immediate", issue.op.immediate, want.op.immediate);
                checkValue("value1", issue.value1, want.value1);
                checkValue("value2", issue.value2, want.value2);
            end else begin
                checkValue("creditReturn without an issue", creditReturn, 0);
            end
        end
    end

    initial begin
        int               fd;
        int               code;
        int               lineCount;
        int               slot;
        logic [8*16-1:0]  cmd;
        logic [8*8-1:0]   busName;
        logic [8*160-1:0] line;
        logic [31:0]      f [10];
        dispatchPacket    pkt;
        issuePacket       entry;

        reset         = 1'b1;
        dispatchValid = 1'b0;
        dispatch      = '0;
        results       = '0;
        fd = $fopen("verification/rsCases.txt", "r");
        if (fd == 0) abortRun("could not open verification/rsCases.txt");
        lineCount = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) lineCount++;
        end
        $fclose(fd);
        cycleLimit = 20 * lineCount;
        fd = $fopen("verification/rsCases.txt", "r");

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        checkValue("issueValid after reset", issueValid, 0);
        checkValue("creditReturn after reset", creditReturn, 0);
        @(posedge clk);
        #1;

        cmd = '0;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            busName = '0;
            if (cmd == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "dispatch") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                               f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                if (code != 10) begin
                    abortRun("malformed dispatch line in the case file");
                end else if (sent - returned >= NumEntries) begin
                    abortRun("a dispatch with no credit left would overflow the station");
                end else begin
                    pkt.op.pc        = f[0];
                    pkt.op.destTag   = f[1][7:0];
                    pkt.op.opcode    = opcodeType'(f[2][3:0]);
                    pkt.op.immediate = f[3];
                    pkt.src1         = '{tag: f[4][7:0], present: f[5][0], value: f[6]};
                    pkt.src2         = '{tag: f[7][7:0], present: f[8][0], value: f[9]};
                    opByPc[f[0]]     = pkt.op;
                    sent++;
                    dispatch         = pkt;
                    dispatchValid    = 1'b1;
                    advance(1);
                end
            end else if (cmd == "bcast") begin
                code = $fscanf(fd, "%s %h %h", busName, f[0], f[1]);
                slot = busFromName(busName);
                if (code != 3 || slot < 0) begin
                    abortRun("malformed bcast line in the case file");
                end else begin
                    results[slot] = '{valid: 1'b1, tag: f[0][7:0], value: f[1]};
                end
            end else if (cmd == "step") begin
                code = $fscanf(fd, "%d", f[0]);
                if (code != 1) abortRun("malformed step line in the case file");
                else advance(int'(f[0]));
            end else if (cmd == "expect") begin
                code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                if (code != 3 || !opByPc.exists(f[0])) begin
                    abortRun("an expect line names a pc that was never dispatched");
                end else begin
                    entry.op     = opByPc[f[0]];
                    entry.value1 = f[1];
                    entry.value2 = f[2];
                    expected.push_back(entry);
                    expectCount++;
                end
            end else begin
                abortRun("unknown command in the case file");
            end
            cmd = '0;
        end
        $fclose(fd);

        while (expected.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk); // room for a stray late issue
        checkValue("credits returned", returned, expectCount);
        if (sent == returned) begin
            $display("All tests passed");
            $finish;
        end else begin
            abortRun("credits are still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: verification/rsCases.txt
# dispatch pc dest opcode imm tag1 present1 value1 tag2 present2 value2 | expect pc value1 value2
# bcast bus tag value (alu mul div load, driven with the next dispatch or step) | step cycles
dispatch 00000100 11 0 0000abcd 01 1 00000005 02 1 00000007
expect 00000100 00000005 00000007
step 2
dispatch 00000200 12 1 00000010 21 0 0 03 1 00000003
dispatch 00000204 13 7 00000000 04 1 00000004 22 0 0
dispatch 00000208 14 8 fffffff0 23 0 0 05 1 00000006
dispatch 0000020c 15 9 00000020 24 0 0 06 1 00000001
step 2
bcast load 24 44444444
bcast div 23 33333333
bcast mul 22 22222222
bcast alu 21 11111111
step 1
expect 00000200 11111111 00000003
expect 00000204 00000004 22222222
expect 00000208 33333333 00000006
expect 0000020c 44444444 00000001
bcast div 30 dddd0001
bcast alu 30 aaaa0001
bcast load 31 eeee0002
bcast mul 31 bbbb0002
dispatch 00000300 16 2 00000000 30 0 0 31 0 0
expect 00000300 aaaa0001 bbbb0002
step 6
dispatch 00000500 20 0 00000000 50 0 0 08 1 00000000
dispatch 00000504 21 1 00000001 08 1 00000001 50 0 0
dispatch 00000508 22 2 00000002 50 0 0 50 0 0
dispatch 0000050c 23 3 00000003 50 0 0 08 1 00000003
dispatch 00000510 24 a 00000004 08 1 00000004 50 0 0
dispatch 00000514 25 b 00000005 50 0 0 08 1 00000005
dispatch 00000518 26 c 00000006 50 0 0 08 1 00000006
dispatch 0000051c 27 6 00000007 08 1 00000007 50 0 0
bcast div 50 0000beef
step 1
expect 00000500 0000beef 00000000
expect 00000504 00000001 0000beef
expect 00000508 0000beef 0000beef
expect 0000050c 0000beef 00000003
expect 00000510 00000004 0000beef
expect 00000514 0000beef 00000005
expect 00000518 0000beef 00000006
expect 0000051c 00000007 0000beef

// File: vlog.f
source/rsPkg.sv
source/operandSnoop.sv
source/entryArray.sv
source/issueSelect.sv
source/reservationStation.sv
verification/reservationStationTb.sv
